/* Bender.yml */
package:
  name: game_display

sources:
  - vgaPkg.sv
  - vgaScanTiming.sv
  - rectSpriteDrawer.sv
  - objectsPriorityMux.sv
  - gameDisplayTop.sv
  - target: test
    files:
      - gameDisplayTb.sv

# top levels: gameDisplayTop (design), gameDisplayTb (simulation)

/* filelist.f */
vgaPkg.sv
vgaScanTiming.sv
rectSpriteDrawer.sv
objectsPriorityMux.sv
gameDisplayTop.sv
gameDisplayTb.sv

/* gameDisplayTb.sv */
//**************************************************
// testbench for the VGA game display pixel path
// models the scan counters three cycles behind and
// checks sync and colour of every output pixel
//**************************************************

`timescale 1ns/1ps

module gameDisplayTb;

	// modelled scan slot with its valid flag
	typedef struct packed {
		logic                          valid;
		logic [vgaPkg::coordWidth-1:0] x;
		logic [vgaPkg::coordWidth-1:0] y;
	} slot_t;

	logic              clk = 1'b0;
	logic              resetN;
	vgaPkg::pixelPos_t playerPos;
	vgaPkg::pixelPos_t enemyPos;
	vgaPkg::rgb332_t   playerRGB;
	vgaPkg::rgb332_t   enemyRGB;
	vgaPkg::rgb332_t   backGroundRGB;
	vgaPkg::rgb24_t    rgbOut;
	logic              hsyncN;
	logic              vsyncN;

	// counter model and its delay line
	int    hPos = 0;
	int    vPos = 0;
	slot_t stage1 = '0;
	slot_t stage2 = '0;
	slot_t stage3 = '0;

	int seed = 32'h47cc7a29;
	int errors = 0;
	int mark = 0;
	int tests = 0;
	int failedTests = 0;
	int cycles = 0;
	// sync pulse bookkeeping
	int hLow = 0;
	int vLow = 0;
	int lineChecks = 0;
	int frameChecks = 0;
	// which colour cases were reached
	int playerHits = 0;
	int enemyHits = 0;
	int overlapHits = 0;
	int edgeHits = 0;

	gameDisplayTop gameDisplayTop_inst (
		.clk           (clk),
		.resetN        (resetN),
		.playerPos     (playerPos),
		.enemyPos      (enemyPos),
		.playerRGB     (playerRGB),
		.enemyRGB      (enemyRGB),
		.backGroundRGB (backGroundRGB),
		.rgbOut        (rgbOut),
		.hsyncN        (hsyncN),
		.vsyncN        (vsyncN)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	// counters run once reset is seen high
	// slots trail the counters by three edges
	always @(posedge clk) begin
		stage1 <= {resetN, 10'(hPos), 10'(vPos)};
		stage2 <= stage1;
		stage3 <= stage2;
		if (resetN) begin
			if (hPos == int'(vgaPkg::hTotal) - 1) begin
				hPos <= 0;
				vPos <= (vPos == int'(vgaPkg::vTotal) - 1) ? 0 : vPos + 1;
			end
			else begin
				hPos <= hPos + 1;
			end
		end
	end

	// stop after four frames of pixels
	always @(posedge clk) begin
		cycles++;
		if (cycles >= 4 * int'(vgaPkg::hTotal) * int'(vgaPkg::vTotal)) begin
			$display("timeout: run did not end after %0d cycles", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// half-open box test
	function automatic logic inRect(input int px, input int py,
		input vgaPkg::pixelPos_t tl, input int w, input int h);
		return (px >= int'(tl.x)) && (px < int'(tl.x) + w) &&
			(py >= int'(tl.y)) && (py < int'(tl.y) + h);
	endfunction

	// each field widened by repeating its lowest bit
	function automatic vgaPkg::rgb24_t expand(input logic [7:0] c);
		vgaPkg::rgb24_t w;
		w.red   = {c[7:5], {5{c[5]}}};
		w.green = {c[4:2], {5{c[2]}}};
		w.blue  = {c[1:0], {6{c[0]}}};
		return w;
	endfunction

	task automatic reportMismatch(input string sig, input int x, input int y,
		input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("ERR %s at x=%0d y=%0d: got %h, expected %h", sig, x, y, got, exp);
	endtask

	// outputs checked on the falling edge
	always @(negedge clk) begin
		int             x;
		int             y;
		logic           act;
		logic           pIn;
		logic           eIn;
		logic [7:0]     expByte;
		logic           expH;
		logic           expV;
		vgaPkg::rgb24_t expRgb;

		x = stage3.x;
		y = stage3.y;
		act = stage3.valid && (x < int'(vgaPkg::hActive)) && (y < int'(vgaPkg::vActive));
		pIn = inRect(x, y, playerPos, 32, 32);
		eIn = inRect(x, y, enemyPos, 48, 24);
		if (!act)
			expByte = 8'h00;
		else if (pIn)
			expByte = playerRGB.raw;
		else if (eIn)
			expByte = enemyRGB.raw;
		else
			expByte = backGroundRGB.raw;
		expRgb = expand(expByte);
		// sync windows start after the front porch
		expH = !(stage3.valid && (x >= int'(vgaPkg::hActive) + int'(vgaPkg::hFront)) &&
			(x < int'(vgaPkg::hActive) + int'(vgaPkg::hFront) + int'(vgaPkg::hSync)));
		expV = !(stage3.valid && (y >= int'(vgaPkg::vActive) + int'(vgaPkg::vFront)) &&
			(y < int'(vgaPkg::vActive) + int'(vgaPkg::vFront) + int'(vgaPkg::vSync)));

		assert (rgbOut.red == expRgb.red)
			else reportMismatch("rgbOut.red", x, y, rgbOut.red, expRgb.red);
		assert (rgbOut.green == expRgb.green)
			else reportMismatch("rgbOut.green", x, y, rgbOut.green, expRgb.green);
		assert (rgbOut.blue == expRgb.blue)
			else reportMismatch("rgbOut.blue", x, y, rgbOut.blue, expRgb.blue);
		assert (hsyncN == expH)
			else reportMismatch("hsyncN", x, y, hsyncN, expH);
		assert (vsyncN == expV)
			else reportMismatch("vsyncN", x, y, vsyncN, expV);

		if (act && pIn && eIn)
			overlapHits++;
		if (act && pIn)
			playerHits++;
		if (act && !pIn && eIn)
			enemyHits++;
		// first pixel past the right or bottom side of the player
		if (act && ((x == int'(playerPos.x) + 32 && inRect(x - 1, y, playerPos, 32, 32)) ||
			(y == int'(playerPos.y) + 32 && inRect(x, y - 1, playerPos, 32, 32))))
			edgeHits++;

		// pulse widths closed at each line end and frame end
		if (stage3.valid) begin
			if (!hsyncN)
				hLow++;
			if (!vsyncN)
				vLow++;
			if (x == int'(vgaPkg::hTotal) - 1) begin
				lineChecks++;
				assert (hLow == int'(vgaPkg::hSync))
					else reportMismatch("hsyncN low cycles", x, y, hLow, vgaPkg::hSync);
				hLow = 0;
				if (y == int'(vgaPkg::vTotal) - 1) begin
					frameChecks++;
					assert (vLow == int'(vgaPkg::vSync) * int'(vgaPkg::hTotal))
						else reportMismatch("vsyncN low cycles", x, y, vLow,
							int'(vgaPkg::vSync) * int'(vgaPkg::hTotal));
					vLow = 0;
				end
			end
		end
	end

	// wait for the first pixel of a line in the counter model
	task automatic waitLine(input int line);
		do
			@(posedge clk);
		while (!(hPos == 0 && vPos == line));
	endtask

	task automatic placeSprites(input int px, input int py, input int ex, input int ey);
		playerPos.x <= 10'(px);
		playerPos.y <= 10'(py);
		enemyPos.x  <= 10'(ex);
		enemyPos.y  <= 10'(ey);
	endtask

	// three distinct layer colours
	task automatic newColours();
		logic [7:0] c;
		c = 8'($random(seed));
		playerRGB.raw     <= c;
		enemyRGB.raw      <= c ^ 8'h5a;
		backGroundRGB.raw <= ~c;
	endtask

	task automatic clearHits();
		playerHits  = 0;
		enemyHits   = 0;
		overlapHits = 0;
		edgeHits    = 0;
	endtask

	task automatic finishTest(input string name, input logic reached, input string what);
		tests++;
		if (!reached) begin
			errors++;
			$display("%s: the stimulus never reached %s", name, what);
		end
		if (errors == mark) begin
			$display("test %s: ok", name);
		end
		else begin
			failedTests++;
			$display("test %s: %0d errors", name, errors - mark);
		end
		mark = errors;
	endtask

	initial begin
		resetN            = 1'b0;
		playerPos.x       = 10'({$random(seed)} % 600);
		playerPos.y       = 10'({$random(seed)} % 440);
		enemyPos.x        = 10'({$random(seed)} % 590);
		enemyPos.y        = 10'({$random(seed)} % 450);
		playerRGB.raw     = 8'h00;
		enemyRGB.raw      = 8'h00;
		backGroundRGB.raw = 8'h00;
		newColours();
		repeat (10) @(posedge clk);
		resetN <= 1'b1;
		// first valid pixel needs the three pipeline stages
		repeat (4) @(posedge clk);
		finishTest("reset", 1'b1, "");

		// random boxes for the first frame
		waitLine(int'(vgaPkg::vActive) + int'(vgaPkg::vFront));
		finishTest("randomSprites", playerHits > 0 && enemyHits > 0, "both boxes");
		// overlapping boxes moved in during vertical blanking
		placeSprites(300, 200, 290, 190);
		clearHits();

		waitLine(5);
		finishTest("syncTiming", lineChecks >= 525 && frameChecks >= 1, "a whole frame");

		waitLine(int'(vgaPkg::vActive) + int'(vgaPkg::vFront));
		finishTest("overlapPriority", overlapHits > 0 && enemyHits > 0, "an overlap pixel");
		// player box touching the enemy box
		// both boxes clipped at the screen edge
		placeSprites(600, 456, 632, 456);
		newColours();
		clearHits();

		waitLine(int'(vgaPkg::vActive) + int'(vgaPkg::vFront));
		finishTest("movedSprites", edgeHits > 0 && enemyHits > 0 && playerHits > 0,
			"the box edges");

		$display("tests %0d, failed %0d, errors %0d", tests, failedTests, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* gameDisplayTop.sv */
//**************************************************
// top level of the VGA game display pixel path
// timing generator, player and enemy drawers and the
// priority mux, three cycles from counter to pins
//**************************************************

`timescale 1ns/1ps

module gameDisplayTop (
	input  logic              clk,
	input  logic              resetN,
	// sprite corners, sampled every cycle
	input  vgaPkg::pixelPos_t playerPos,
	input  vgaPkg::pixelPos_t enemyPos,
	// layer colours
	input  vgaPkg::rgb332_t   playerRGB,
	input  vgaPkg::rgb332_t   enemyRGB,
	input  vgaPkg::rgb332_t   backGroundRGB,
	output vgaPkg::rgb24_t    rgbOut,
	output logic              hsyncN,
	output logic              vsyncN
);

	// scan straight from the counters
	vgaPkg::scan_t   scan0;
	// scan one stage later, from the player drawer
	vgaPkg::scan_t   scan1;

	logic            playerDrawReq;
	vgaPkg::rgb332_t playerDrawRGB;
	logic            enemyDrawReq;
	vgaPkg::rgb332_t enemyDrawRGB;

	vgaScanTiming vgaScanTiming_inst (
		.clk    (clk),
		.resetN (resetN),
		.scan   (scan0)
	);

	// player box 32x32
	rectSpriteDrawer #(
		.spriteWidth  (32),
		.spriteHeight (32)
	) playerDrawer (
		.clk       (clk),
		.resetN    (resetN),
		.scanIn    (scan0),
		.topLeft   (playerPos),
		.spriteRGB (playerRGB),
		.drawReq   (playerDrawReq),
		.rgb       (playerDrawRGB),
		.scanOut   (scan1)
	);

	// enemy box 48x24, its delayed scan matches scan1 and stays open
	rectSpriteDrawer #(
		.spriteWidth  (48),
		.spriteHeight (24)
	) enemyDrawer (
		.clk       (clk),
		.resetN    (resetN),
		.scanIn    (scan0),
		.topLeft   (enemyPos),
		.spriteRGB (enemyRGB),
		.drawReq   (enemyDrawReq),
		.rgb       (enemyDrawRGB),
		.scanOut   ()
	);

	objectsPriorityMux objectsPriorityMux_inst (
		.clk           (clk),
		.resetN        (resetN),
		.scan          (scan1),
		.playerDrawReq (playerDrawReq),
		.playerRGB     (playerDrawRGB),
		.enemyDrawReq  (enemyDrawReq),
		.enemyRGB      (enemyDrawRGB),
		.backGroundRGB (backGroundRGB),
		.rgbOut        (rgbOut),
		.hsyncN        (hsyncN),
		.vsyncN        (vsyncN)
	);

endmodule

/* objectsPriorityMux.sv */
//**************************************************
// priority colour mux, one cycle latency
// player over enemy over background, black outside
// the active area, RGB332 widened to 24 bits
//**************************************************

`timescale 1ns/1ps

module objectsPriorityMux (
	input  logic            clk,
	input  logic            resetN,
	input  vgaPkg::scan_t   scan,
	// player layer
	input  logic            playerDrawReq,
	input  vgaPkg::rgb332_t playerRGB,
	// enemy layer
	input  logic            enemyDrawReq,
	input  vgaPkg::rgb332_t enemyRGB,
	// last priority
	input  vgaPkg::rgb332_t backGroundRGB,
	output vgaPkg::rgb24_t  rgbOut,
	output logic            hsyncN,
	output logic            vsyncN
);

	// registered colour byte
	vgaPkg::rgb332_t tmpRGB;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			tmpRGB.raw <= 8'h00;
			hsyncN     <= 1'b1;
			vsyncN     <= 1'b1;
		end
		else begin
			// blank in porches and sync
			if (!scan.active)
				tmpRGB.raw <= 8'h00;
			else if (playerDrawReq)
				tmpRGB.raw <= playerRGB.raw;
			else if (enemyDrawReq)
				tmpRGB.raw <= enemyRGB.raw;
			else
				tmpRGB.raw <= backGroundRGB.raw;

			// sync kept in step with the colour
			hsyncN <= scan.hsyncN;
			vsyncN <= scan.vsyncN;
		end
	end

	// repeat the low bit of each field to fill 8 bits
	assign rgbOut.red = {
		tmpRGB.fields.red,
		{5{tmpRGB.fields.red[0]}}
	};
	assign rgbOut.green = {
		tmpRGB.fields.green,
		{5{tmpRGB.fields.green[0]}}
	};
	// blue has only two bits, so six copies
	assign rgbOut.blue = {
		tmpRGB.fields.blue,
		{6{tmpRGB.fields.blue[0]}}
	};

endmodule

/* rectSpriteDrawer.sv */
//**************************************************
// rectangular sprite drawer, one cycle latency
// raises drawReq over a half-open box at topLeft and
// passes its colour and the delayed scan onward
//**************************************************

`timescale 1ns/1ps

module rectSpriteDrawer #(
	parameter int spriteWidth  = 32,
	parameter int spriteHeight = 32
) (
	input  logic              clk,
	input  logic              resetN,
	input  vgaPkg::scan_t     scanIn,
	input  vgaPkg::pixelPos_t topLeft,
	input  vgaPkg::rgb332_t   spriteRGB,
	output logic              drawReq,
	output vgaPkg::rgb332_t   rgb,
	output vgaPkg::scan_t     scanOut
);

	// one extra bit so a box near the right or bottom edge does not wrap
	logic [vgaPkg::coordWidth:0] rightEdge;
	logic [vgaPkg::coordWidth:0] bottomEdge;
	logic                        insideX;
	logic                        insideY;

	assign rightEdge  = {1'b0, topLeft.x} + (vgaPkg::coordWidth + 1)'(spriteWidth);
	assign bottomEdge = {1'b0, topLeft.y} + (vgaPkg::coordWidth + 1)'(spriteHeight);

	// left and top inclusive, right and bottom exclusive
	assign insideX = (scanIn.pos.x >= topLeft.x) && ({1'b0, scanIn.pos.x} < rightEdge);
	assign insideY = (scanIn.pos.y >= topLeft.y) && ({1'b0, scanIn.pos.y} < bottomEdge);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawReq        <= 1'b0;
			scanOut.pos    <= '0;
			scanOut.active <= 1'b0;
			scanOut.hsyncN <= 1'b1;
			scanOut.vsyncN <= 1'b1;
		end
		else begin
			drawReq <= scanIn.active && insideX && insideY;
			// scan travels beside the request
			scanOut <= scanIn;
		end
	end

	// colour register
	always_ff @(posedge clk) begin
		rgb <= spriteRGB;
	end

endmodule

/* vgaPkg.sv */
//**************************************************
// shared definitions for the VGA game display
// frame timing, pixel position, scan slot and colour
// types, referenced by scoped names
//**************************************************

package vgaPkg;

	// coordinate width for x and y
	localparam int coordWidth = 10;

	// horizontal timing in pixels
	localparam logic [coordWidth-1:0] hActive = 10'd640;
	localparam logic [coordWidth-1:0] hFront  = 10'd16;
	localparam logic [coordWidth-1:0] hSync   = 10'd96;
	localparam logic [coordWidth-1:0] hBack   = 10'd48;
	localparam logic [coordWidth-1:0] hTotal  = hActive + hFront + hSync + hBack;

	// vertical timing in lines
	localparam logic [coordWidth-1:0] vActive = 10'd480;
	localparam logic [coordWidth-1:0] vFront  = 10'd10;
	localparam logic [coordWidth-1:0] vSync   = 10'd2;
	localparam logic [coordWidth-1:0] vBack   = 10'd33;
	localparam logic [coordWidth-1:0] vTotal  = vActive + vFront + vSync + vBack;

	// one pixel position on the screen
	typedef struct packed {
		logic [coordWidth-1:0] x;
		logic [coordWidth-1:0] y;
	} pixelPos_t;

	// one pixel slot of the scan, sync active low
	typedef struct packed {
		pixelPos_t pos;
		logic      active;
		logic      hsyncN;
		logic      vsyncN;
	} scan_t;

	// RGB332 byte, chosen as a whole, decoded per field
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [2:0] red;
			logic [2:0] green;
			logic [1:0] blue;
		} fields;
	} rgb332_t;

	// widened colour toward the DAC
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb24_t;

endpackage

/* vgaScanTiming.sv */
//**************************************************
// scan timing generator for a 640x480 60 Hz frame
// one pixel per clk, registered scan struct with
// position, active area and both sync pulses
//**************************************************

`timescale 1ns/1ps

module vgaScanTiming (
	input  logic          clk,
	input  logic          resetN,
	output vgaPkg::scan_t scan
);

	// raw counters
	logic [vgaPkg::coordWidth-1:0] hPos;
	logic [vgaPkg::coordWidth-1:0] vPos;

	// decoded flags for the current counter state
	logic lineEnd;
	logic frameEnd;
	logic inActive;
	logic inHsync;
	logic inVsync;

	assign lineEnd  = (hPos == vgaPkg::hTotal - 1'b1);
	assign frameEnd = (vPos == vgaPkg::vTotal - 1'b1);
	assign inActive = (hPos < vgaPkg::hActive) && (vPos < vgaPkg::vActive);

	// sync window begins after the front porch
	assign inHsync = (hPos >= vgaPkg::hActive + vgaPkg::hFront) &&
		(hPos < vgaPkg::hActive + vgaPkg::hFront + vgaPkg::hSync);
	assign inVsync = (vPos >= vgaPkg::vActive + vgaPkg::vFront) &&
		(vPos < vgaPkg::vActive + vgaPkg::vFront + vgaPkg::vSync);

	// pixel and line counters
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hPos <= '0;
			vPos <= '0;
		end
		else begin
			if (lineEnd) begin
				hPos <= '0;
				// step a line at the end of each row
				if (frameEnd)
					vPos <= '0;
				else
					vPos <= vPos + 1'b1;
			end
			else begin
				hPos <= hPos + 1'b1;
			end
		end
	end

	// scan slot lags the counters by one cycle
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			scan.pos    <= '0;
			scan.active <= 1'b0;
			scan.hsyncN <= 1'b1;
			scan.vsyncN <= 1'b1;
		end
		else begin
			scan.pos.x  <= hPos;
			scan.pos.y  <= vPos;
			scan.active <= inActive;
			scan.hsyncN <= ~inHsync;
			scan.vsyncN <= ~inVsync;
		end
	end

endmodule
